// File: source/spiProtoPkg.sv
// SPI frame constants and shift byte view types, imported by the protocol-level modules
`default_nettype none

package spiProtoPkg;

   // ---------------------------------------------------------------------
   // Frame geometry
   // ---------------------------------------------------------------------

   // Bits per SPI byte, MSB first
   localparam int frameBits = 8;

   // Shift register byte, seen as a command or as a data word
   typedef union packed {
      // Command view, address on top and read flag in bit 0
      struct packed {
         logic [frameBits-2:0] addr;
         logic                 read;
      } cmd;
      // Plain data view
      logic [frameBits-1:0] data;
   } spiByte_u;

   // ---------------------------------------------------------------------
   // Frame FSM
   // ---------------------------------------------------------------------

   typedef enum logic [2:0] {
      idle, command, readLoad, readOut, writeData, writeMem, done
   } fsmState_e;

endpackage

`default_nettype wire

// File: source/memPkg.sv
// Memory geometry and pin debounce constants, imported by storage and conditioning modules
`default_nettype none

package memPkg;

   // ---------------------------------------------------------------------
   // Storage geometry
   // ---------------------------------------------------------------------

   localparam int addrWidth = 7;
   localparam int dataWidth = 8;
   // One word per address
   localparam int memDepth  = 128;

   // ---------------------------------------------------------------------
   // Input conditioning
   // ---------------------------------------------------------------------

   // Stable clocks needed before a pin change is taken
   localparam int debounceCycles    = 3;
   // Must hold debounceCycles
   localparam int debounceCountBits = 2;

endpackage

`default_nettype wire

// File: source/inputConditioner.sv
// Cleans one raw SPI pin: synchronizer, debounce filter and one-clock edge pulses
`default_nettype none

module inputConditioner #(
   // Idle level of the pin, csN idles high
   parameter logic resetLevel = 1'b0
) (
   input  logic clk,
   input  logic arstN,
   input  logic noisy,
   output logic conditioned,
   output logic rise,
   output logic fall
);
   import memPkg::*;

   logic                         syncMeta;
   logic                         syncOut;
   logic                         condPrev;
   logic [debounceCountBits-1:0] stableCount;

   // Two-flop synchronizer
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         syncMeta <= resetLevel;
         syncOut  <= resetLevel;
      end else begin
         syncMeta <= noisy;
         syncOut  <= syncMeta;
      end
   end

   // Debounce filter
   // Count clocks of disagreement, any return to the old level restarts
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         stableCount <= '0;
         conditioned <= resetLevel;
      end else if (syncOut == conditioned) begin
         stableCount <= '0;
      end else if (stableCount == debounceCountBits'(debounceCycles)) begin
         // Held long enough, accept it
         stableCount <= '0;
         conditioned <= syncOut;
      end else begin
         stableCount <= stableCount + 1'b1;
      end
   end

   // Edge pulses, one clock after the filtered change
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         condPrev <= resetLevel;
         rise     <= 1'b0;
         fall     <= 1'b0;
      end else begin
         condPrev <= conditioned;
         rise     <= conditioned & ~condPrev;
         fall     <= ~conditioned & condPrev;
      end
   end

endmodule

`default_nettype wire

// File: source/bitCounter.sv
// Counts rising sclk edges inside a frame and flags every completed byte to the FSM
`default_nettype none

module bitCounter (
   input  logic clk,
   input  logic arstN,
   input  logic csActive,
   input  logic sclkRise,
   output logic byteDone,
   output logic secondByte
);
   import spiProtoPkg::*;

   // Bit position inside the current byte
   logic [$clog2(frameBits)-1:0] bitCount;

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         bitCount   <= '0;
         byteDone   <= 1'b0;
         secondByte <= 1'b0;
      end else if (!csActive) begin
         // Outside a frame, start over
         bitCount   <= '0;
         byteDone   <= 1'b0;
         secondByte <= 1'b0;
      end else begin
         byteDone <= 1'b0;
         if (sclkRise) begin
            if (int'(bitCount) == frameBits - 1) begin
               // Wrap at the last bit
               bitCount   <= '0;
               byteDone   <= 1'b1;
               secondByte <= 1'b1;
            end else begin
               bitCount <= bitCount + 1'b1;
            end
         end
      end
   end

   // A byte only completes inside a frame
   byteDoneInFrame: assert property (
      @(posedge clk) disable iff (!arstN) byteDone |-> csActive
   );

endmodule

`default_nettype wire

// File: source/spiShiftReg.sv
// SPI shift register: serial in on sclk rise, parallel load from memory, miso flop on sclk fall
`default_nettype none

module spiShiftReg (
   input  logic                                clk,
   input  logic                                arstN,
   input  logic                                sclkRise,
   input  logic                                sclkFall,
   input  logic                                mosiBit,
   input  logic                                srLoad,
   input  logic [spiProtoPkg::frameBits-1:0]   loadData,
   output spiProtoPkg::spiByte_u               shiftByte,
   output logic                                miso
);
   import spiProtoPkg::*;

   // ---------------------------------------------------------------------
   // Shift register
   // ---------------------------------------------------------------------

   // Parallel load wins over a shift
   always_ff @(posedge clk) begin
      if (srLoad) begin
         shiftByte.data <= loadData;
      end else if (sclkRise) begin
         // MSB first, new bit enters at the bottom
         shiftByte.data <= {shiftByte.data[frameBits-2:0], mosiBit};
      end
   end

   // ---------------------------------------------------------------------
   // Output flop
   // ---------------------------------------------------------------------

   // Master samples on rise, so miso moves on fall
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         miso <= 1'b0;
      end else if (sclkFall) begin
         miso <= shiftByte.data[frameBits-1];
      end
   end

   // Load slot must not eat a mosi bit
   loadNotOnShift: assert property (
      @(posedge clk) disable iff (!arstN) !(srLoad && sclkRise)
   );

endmodule

`default_nettype wire

// File: source/dataMemory.sv
// Synchronous word memory with registered read, addressed by the latched SPI command address
`default_nettype none

module dataMemory (
   input  logic                         clk,
   input  logic                         writeEnable,
   input  logic [memPkg::addrWidth-1:0] address,
   input  logic [memPkg::dataWidth-1:0] dataIn,
   output logic [memPkg::dataWidth-1:0] dataOut
);
   import memPkg::*;

   logic [dataWidth-1:0] mem [memDepth];

   // Read returns the old word on a write to the same address
   always_ff @(posedge clk) begin
      if (writeEnable) begin
         mem[address] <= dataIn;
      end
      dataOut <= mem[address];
   end

   // Address comes from the FSM latch, must be settled before a store
   addrKnownOnWrite: assert property (
      @(posedge clk) writeEnable |-> !$isunknown(address)
   );

endmodule

`default_nettype wire

// File: source/spiFsm.sv
// Frame FSM: latches the command address and steers memory write, shift load and miso enable
`default_nettype none

module spiFsm (
   input  logic                         clk,
   input  logic                         arstN,
   input  logic                         csActive,
   input  logic                         byteDone,
   input  logic                         secondByte,
   input  spiProtoPkg::spiByte_u        shiftByte,
   output logic [memPkg::addrWidth-1:0] addrLatch,
   output logic                         memWe,
   output logic                         srLoad,
   output logic                         misoEn
);
   import spiProtoPkg::*;

   fsmState_e state;

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         state     <= idle;
         addrLatch <= '0;
         memWe     <= 1'b0;
         srLoad    <= 1'b0;
         misoEn    <= 1'b0;
      end else begin
         // Strobes, one clock each
         memWe  <= 1'b0;
         srLoad <= 1'b0;
         if (!csActive) begin
            // csN high ends any frame
            state  <= idle;
            misoEn <= 1'b0;
         end else begin
            unique case (state)
               idle: begin
                  state <= command;
               end
               command: begin
                  if (byteDone) begin
                     addrLatch <= shiftByte.cmd.addr;
                     if (shiftByte.cmd.read) begin
                        state <= readLoad;
                     end else begin
                        state <= writeData;
                     end
                  end
               end
               // Memory reads addrLatch now, word is ready next clock
               readLoad: begin
                  srLoad <= 1'b1;
                  misoEn <= 1'b1;
                  state  <= readOut;
               end
               // Hold until csN rises
               readOut: begin
                  state <= readOut;
               end
               writeData: begin
                  // Second byte in the shift register
                  if (byteDone && secondByte) begin
                     memWe <= 1'b1;
                     state <= writeMem;
                  end
               end
               writeMem: begin
                  state <= done;
               end
               done: begin
                  state <= done;
               end
               default: begin
                  state <= idle;
               end
            endcase
         end
      end
   end

   // Read drive and store never overlap
   noWriteWhileDriving: assert property (
      @(posedge clk) disable iff (!arstN) memWe |-> !misoEn
   );

endmodule

`default_nettype wire

// File: source/spiMemory.sv
// Top of the SPI slave memory; raw pins in, miso and its tristate enable out
`default_nettype none

module spiMemory (
   input  logic clk,
   input  logic arstN,
   input  logic sclk,
   input  logic csN,
   input  logic mosi,
   output logic miso,
   output logic misoEn
);
   import spiProtoPkg::*;
   import memPkg::*;

   logic                 csCond;
   logic                 csActive;
   logic                 sclkRise;
   logic                 sclkFall;
   logic                 mosiBit;
   logic                 byteDone;
   logic                 secondByte;
   logic                 memWe;
   logic                 srLoad;
   logic [addrWidth-1:0] addrLatch;
   logic [dataWidth-1:0] memData;
   spiByte_u             shiftByte;

   // ---------------------------------------------------------------------
   // Pin conditioning
   // ---------------------------------------------------------------------

   // csN idles high
   inputConditioner #(.resetLevel(1'b1)) csCond_inst (
      .clk(clk), .arstN(arstN), .noisy(csN),
      .conditioned(csCond), .rise(), .fall()
   );
   assign csActive = ~csCond;

   // Only the edges of sclk matter
   inputConditioner #(.resetLevel(1'b0)) sclkCond_inst (
      .clk(clk), .arstN(arstN), .noisy(sclk),
      .conditioned(), .rise(sclkRise), .fall(sclkFall)
   );

   inputConditioner #(.resetLevel(1'b0)) mosiCond_inst (
      .clk(clk), .arstN(arstN), .noisy(mosi),
      .conditioned(mosiBit), .rise(), .fall()
   );

   // ---------------------------------------------------------------------
   // Frame control and datapath
   // ---------------------------------------------------------------------

   bitCounter bitCounter_inst (
      .clk(clk), .arstN(arstN), .csActive(csActive), .sclkRise(sclkRise),
      .byteDone(byteDone), .secondByte(secondByte)
   );

   spiFsm spiFsm_inst (
      .clk(clk), .arstN(arstN), .csActive(csActive), .byteDone(byteDone),
      .secondByte(secondByte), .shiftByte(shiftByte), .addrLatch(addrLatch),
      .memWe(memWe), .srLoad(srLoad), .misoEn(misoEn)
   );

   spiShiftReg spiShiftReg_inst (
      .clk(clk), .arstN(arstN), .sclkRise(sclkRise), .sclkFall(sclkFall),
      .mosiBit(mosiBit), .srLoad(srLoad), .loadData(memData),
      .shiftByte(shiftByte), .miso(miso)
   );

   // Stores the data view of the second byte
   dataMemory dataMemory_inst (
      .clk(clk), .writeEnable(memWe), .address(addrLatch),
      .dataIn(shiftByte.data), .dataOut(memData)
   );

endmodule

`default_nettype wire

// File: tests/spiMemoryTb.sv
// Testbench for the SPI slave memory; replays the frames listed in tests/spiMemoryCases.txt
`default_nettype none

module spiMemoryTb;

   localparam int halfClocks = 16;
   localparam int byteBits   = 8;

   logic clk = 1'b0;
   logic arstN;
   logic sclk;
   logic csN;
   logic mosi;
   logic miso;
   logic misoEn;

   int errorCount = 0;
   int checkCount = 0;
   int cycleCount = 0;
   int cycleLimit = 0;

   // Case table from the file
   string      caseOp[$];
   logic [6:0] caseAddr[$];
   logic [7:0] caseData[$];
   string      caseName[$];

   spiMemory spiMemory_inst (
      .clk(clk), .arstN(arstN), .sclk(sclk), .csN(csN), .mosi(mosi),
      .miso(miso), .misoEn(misoEn)
   );

   always #2 clk = ~clk;

   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
   end

   // ---------------------------------------------------------------------
   // Helpers
   // ---------------------------------------------------------------------

   task automatic waitClocks(input int n);
      repeat (n) @(posedge clk);
   endtask

   task automatic checkValue(input string testName, input logic [7:0] expected,
                             input logic [7:0] actual);
      checkCount++;
      if (actual !== expected) begin
         errorCount++;
         $display("FAIL %s expected %02h actual %02h", testName, expected, actual);
      end
   endtask

   // Lines starting with # are skipped
   task automatic loadCases(output bit ok);
      int         fd;
      int         got;
      string      lineBuf;
      string      opStr;
      string      nameStr;
      logic [7:0] addrVal;
      logic [7:0] dataVal;
      ok = 1'b0;
      fd = $fopen("tests/spiMemoryCases.txt", "r");
      if (fd != 0) begin
         while (!$feof(fd)) begin
            got = $fgets(lineBuf, fd);
            if (got > 0 && lineBuf.len() > 1 && lineBuf.substr(0, 0) != "#") begin
               if ($sscanf(lineBuf, "%s %h %h %s", opStr, addrVal, dataVal, nameStr) == 4) begin
                  caseOp.push_back(opStr);
                  caseAddr.push_back(addrVal[6:0]);
                  caseData.push_back(dataVal);
                  caseName.push_back(nameStr);
               end
            end
         end
         $fclose(fd);
         ok = (caseOp.size() > 0);
      end
   endtask

   // ---------------------------------------------------------------------
   // SPI master
   // ---------------------------------------------------------------------

   // Mode 0 frame, mosi moves with sclk low, miso sampled just before each rise
   task automatic runFrame(input string testName, input logic [7:0] cmdByte,
                           input logic [7:0] dataByte, input bit isRead,
                           input int bitTotal, input bit withGlitch,
                           output logic [7:0] misoByte);
      logic [15:0] frameWord;
      logic [31:0] rnd;
      logic        txBit;
      logic        expEn;
      int          i;
      frameWord = {cmdByte, dataByte};
      misoByte  = '0;
      @(posedge clk);
      csN <= 1'b0;
      // csN needs its trip through the conditioner
      waitClocks(halfClocks);
      for (i = 0; i < bitTotal; i++) begin
         rnd   = $urandom;
         // Slave ignores mosi during read data
         txBit = (isRead && i >= byteBits) ? rnd[0] : frameWord[15 - i];
         @(posedge clk);
         sclk <= 1'b0;
         mosi <= txBit;
         if (withGlitch && i == 11) begin
            // 2-clock spike while low
            waitClocks(7);
            sclk <= 1'b1;
            waitClocks(2);
            sclk <= 1'b0;
            waitClocks(halfClocks - 11);
         end else begin
            waitClocks(halfClocks - 2);
         end
         @(negedge clk);
         expEn = isRead && (i >= byteBits);
         checkValue({testName, " misoEn"}, {7'b0, expEn}, {7'b0, misoEn});
         if (isRead && i >= byteBits) begin
            misoByte[15 - i] = miso;
         end
         @(posedge clk);
         sclk <= 1'b1;
         if (withGlitch && i == 13) begin
            // 2-clock dip while high
            waitClocks(8);
            sclk <= 1'b0;
            waitClocks(2);
            sclk <= 1'b1;
            waitClocks(halfClocks - 11);
         end else begin
            waitClocks(halfClocks - 1);
         end
      end
      @(posedge clk);
      sclk <= 1'b0;
      waitClocks(halfClocks);
      csN <= 1'b1;
      waitClocks(2 * halfClocks);
      @(negedge clk);
      checkValue({testName, " misoEn after csN"}, 8'h00, {7'b0, misoEn});
   endtask

   task automatic runCase(input string op, input logic [6:0] addr,
                          input logic [7:0] dataByte, input string name);
      logic [7:0] misoByte;
      if (op == "write") begin
         runFrame(name, {addr, 1'b0}, dataByte, 1'b0, 16, 1'b0, misoByte);
      end else if (op == "read") begin
         runFrame(name, {addr, 1'b1}, 8'h00, 1'b1, 16, 1'b0, misoByte);
         checkValue(name, dataByte, misoByte);
      end else if (op == "abort") begin
         // csN rises 4 bits into the data byte
         runFrame(name, {addr, 1'b0}, dataByte, 1'b0, 12, 1'b0, misoByte);
      end else if (op == "glitch") begin
         runFrame(name, {addr, 1'b0}, dataByte, 1'b0, 16, 1'b1, misoByte);
      end else begin
         errorCount++;
         $display("Unknown operation %s in case %s", op, name);
      end
   endtask

   // ---------------------------------------------------------------------
   // Main sequence
   // ---------------------------------------------------------------------

   initial begin
      bit loaded;
      int caseIdx;
      arstN <= 1'b0;
      sclk  <= 1'b0;
      csN   <= 1'b1;
      mosi  <= 1'b0;
      void'($urandom(32'hda83b1fa));
      loadCases(loaded);
      if (!loaded) begin
         $display("Could not read any case from tests/spiMemoryCases.txt");
         $display("TESTS FAILED");
         $finish;
      end else begin
         // One spare case length covers reset and the idle stretch
         cycleLimit = (caseOp.size() + 1) * 16 * 32 * 2;
         waitClocks(5);
         arstN <= 1'b1;
         // Idle bus, nothing driven
         repeat (8) begin
            waitClocks(8);
            @(negedge clk);
            checkValue("idle misoEn", 8'h00, {7'b0, misoEn});
         end
         for (caseIdx = 0; caseIdx < caseOp.size(); caseIdx++) begin
            runCase(caseOp[caseIdx], caseAddr[caseIdx], caseData[caseIdx], caseName[caseIdx]);
         end
         $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
         if (errorCount == 0) begin
            $display("TESTS PASSED");
         end else begin
            $display("TESTS FAILED");
         end
         $finish;
      end
   end

   // Hung DUT or master guard
   initial begin
      wait (cycleLimit > 0 && cycleCount >= cycleLimit);
      $display("Timeout: run went past %0d clock cycles", cycleLimit);
      $display("TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: tests/spiMemoryCases.txt
# op addr(hex) data(hex) name; read expects data, abort and glitch send data
# abort raises csN after 12 bits, glitch adds 2-clock sclk glitches
write 00 a5 wrAddr0
write 7f 3c wrAddr127
read 00 a5 rdAddr0
read 7f 3c rdAddr127
write 01 ff wrAddr1
write 2a 00 wrAddr42
write 55 81 wrAddr85
write 40 96 wrAddr64
read 01 ff rdAddr1
read 2a 00 rdAddr42
read 55 81 rdAddr85
read 40 96 rdAddr64
write 13 5a wrAddr19
abort 13 e7 abortAddr19
read 13 5a rdAfterAbort19
write 2a c3 overwrite42
read 2a c3 rdOverwrite42
glitch 66 b4 glitchAddr102
read 66 b4 rdGlitch102
glitch 00 1e glitchAddr0
read 00 1e rdGlitch0

// File: spiMemory.f
source/spiProtoPkg.sv
source/memPkg.sv
source/inputConditioner.sv
source/bitCounter.sv
source/spiShiftReg.sv
source/dataMemory.sv
source/spiFsm.sv
source/spiMemory.sv
tests/spiMemoryTb.sv

// File: runSim.sh
#!/usr/bin/env bash
# Build the SPI memory testbench with Verilator, run it, and check the log

cd "$(dirname "$0")" || exit 1

buildDir=build
logFile="$buildDir/sim.log"

mkdir -p "$buildDir"
if [ $? -ne 0 ]; then
   echo "Could not create $buildDir"
   exit 1
fi

verilator --binary --timing --assert -f spiMemory.f --top-module spiMemoryTb \
   -Mdir "$buildDir/obj" -o spiMemorySim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$buildDir/obj/spiMemorySim" > "$logFile" 2>&1
runStatus=$?
cat "$logFile"
if [ $runStatus -ne 0 ]; then
   echo "Simulation exited with status $runStatus"
   exit 1
fi

if grep -qx "TESTS PASSED" "$logFile"; then
   exit 0
else
   exit 1
fi
